//--- flist.f
verilog/rv32i_types.sv
verilog/icache_types.sv
verilog/icache_metadata_check.sv
verilog/icache_control.sv
verilog/icache.sv
verification/pmem_model.sv
verification/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module icache_tb
./obj_dir/Vicache_tb | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- verification/icache_tb.sv
`default_nettype none

module icache_tb
  import rv32i_types::*;
  import icache_types::*;
();

  localparam int s_index  = 3;
  localparam int num_sets = 2**s_index;

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  logic      mem_read = 1'b0;
  rv32i_word mem_address = '0;
  logic      mem_resp;
  rv32i_word mem_rdata;
  logic      pmem_read;
  rv32i_word pmem_address;
  logic      pmem_resp;
  cache_line pmem_rdata;
  int        pmem_reads;

  rv32i_word tbl_addr [$];    // request address.
  bit        tbl_refill [$];  // refill expected before the response.
  rv32i_word tbl_line [$];    // pmem_address of that refill.
  int        accept_cycle [$];  // loop cycle whose edge took each request.

  // reference model of tags, valid bits and tree bits.
  rv32i_word m_tag [num_sets][num_ways];
  bit        m_valid [num_sets][num_ways];
  plru_t     m_plru [num_sets];

  logic      s_resp;  // sampled on the falling edge.
  logic      s_pread;
  logic      s_pdone;
  rv32i_word s_rdata;
  rv32i_word s_paddr;

  integer seed = 32'h26c517c5;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     cycle_limit = 0;
  int     expected_reads = 0;

  always #5 clk = ~clk;

  icache #(.s_index(s_index)) u_dut (
    .clk, .rst, .mem_read, .mem_address, .pmem_resp, .pmem_rdata,
    .mem_resp, .mem_rdata, .pmem_read, .pmem_address
  );

  pmem_model memory (
    .clk, .rst, .pmem_read, .pmem_address, .pmem_resp, .pmem_rdata,
    .read_count (pmem_reads)
  );

  function automatic rv32i_word mem_word(rv32i_word addr);
    rv32i_word base;
    base = {addr[31:s_offset], {s_offset{1'b0}}};
    return (base + {27'b0, addr[4:2], 2'b00}) ^ 32'h5a5a_0000;
  endfunction

  // an access to way w turns the tree bits toward the other side.
  function automatic plru_t point_away(plru_t bits, int w);
    plru_t next;
    next = bits;
    if (w < 2) begin
      next[0] = 1'b1;
      next[1] = (w == 0);
    end else begin
      next[0] = 1'b0;
      next[2] = (w == 2);
    end
    return next;
  endfunction

  function automatic bit model_access(rv32i_word addr);
    int        set;
    int        way;
    int        w;
    rv32i_word tag;
    set = int'(addr[s_offset +: s_index]);
    tag = addr >> (s_offset + s_index);
    way = -1;
    for (w = 0; w < num_ways; w++) begin
      if (m_valid[set][w] && m_tag[set][w] == tag) way = w;
    end
    if (way >= 0) begin
      m_plru[set] = point_away(m_plru[set], way);
      return 1'b0;
    end
    for (w = num_ways - 1; w >= 0; w--) begin
      if (!m_valid[set][w]) way = w;  // lowest free way.
    end
    if (way < 0) way = m_plru[set][0] ? 2 + int'(m_plru[set][2]) : int'(m_plru[set][1]);
    m_valid[set][way] = 1'b1;
    m_tag[set][way]   = tag;
    m_plru[set]       = point_away(m_plru[set], way);
    return 1'b1;
  endfunction

  task automatic add_entry(input rv32i_word addr);
    bit refill;
    refill = model_access(addr);
    if (refill) expected_reads++;
    tbl_addr.push_back(addr);
    tbl_refill.push_back(refill);
    tbl_line.push_back({addr[31:s_offset], {s_offset{1'b0}}});
  endtask

  task automatic check_word(input string name, input rv32i_word got, input rv32i_word exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  always @(negedge clk) begin
    s_resp  = mem_resp;
    s_rdata = mem_rdata;
    s_pread = pmem_read;
    s_pdone = pmem_read && pmem_resp;
    s_paddr = pmem_address;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, table not finished", cycles);
      $display("errors: %0d, checks: %0d", errors, checks);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int        next_idx;
    int        resp_idx;
    int        pending;
    int        refills;
    int        loop_cycle;
    int        k;
    int        pick;
    int        rnd;
    bit        take;
    rv32i_word line_seen;
    next_idx   = 0;
    resp_idx   = 0;
    pending    = 0;
    refills    = 0;
    loop_cycle = 0;
    line_seen  = '0;
    for (k = 0; k < num_sets; k++) m_plru[k] = '0;

    // --------------------
    add_entry(32'h0000_1024);  // cold miss.
    for (k = 0; k < 8; k++) add_entry(32'h0000_1020 + k * 4);
    for (k = 0; k < 8; k++) add_entry(32'h0000_2040 + (k % 4) * 32'h1004);
    add_entry(32'h0000_6050);  // fifth line in set 2.
    add_entry(32'h0000_3044);
    add_entry(32'h0000_4048);
    add_entry(32'h0000_504c);
    add_entry(32'h0000_2040);
    // 16 lines packed into the top two sets.
    for (k = 0; k < 60; k++) begin
      rnd  = $random(seed);
      pick = rnd & 15;
      add_entry(32'h0010_0000 + ((pick >> 1) << (s_offset + s_index))
                + ((num_sets - 2 + (pick & 1)) << s_offset) + (((rnd >> 4) & 7) << 2));
    end
    cycle_limit = 20 * tbl_addr.size() + 100;

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (4) begin
      @(posedge clk);
      check_count("mem_resp", int'(s_resp), 0);
      check_count("pmem_read", int'(s_pread), 0);
    end

    // --------------------
    while (resp_idx < tbl_addr.size()) begin
      @(posedge clk);
      loop_cycle++;
      if (s_pdone) begin
        refills++;
        line_seen = s_paddr;
      end
      take = mem_read && (s_resp || pending == 0);
      if (s_resp && pending == 0) begin
        errors++;
        $display("mem_resp arrived with no request outstanding");
      end else if (s_resp) begin
        check_word($sformatf("mem_rdata[%0d]", resp_idx), s_rdata,
                   mem_word(tbl_addr[resp_idx]));
        check_count($sformatf("refills[%0d]", resp_idx), refills,
                    int'(tbl_refill[resp_idx]));
        if (tbl_refill[resp_idx]) begin
          check_word("pmem_address", line_seen, tbl_line[resp_idx]);
        end else begin
          // a hit answers in the cycle right after its accepting edge.
          check_count($sformatf("hit latency[%0d]", resp_idx),
                      loop_cycle - accept_cycle[resp_idx], 1);
        end
        refills = 0;
        pending--;
        resp_idx++;
      end
      if (take) begin
        pending++;
        accept_cycle.push_back(loop_cycle);
      end
      if (take || !mem_read) begin
        if (next_idx < tbl_addr.size()) begin
          mem_read    <= 1'b1;
          mem_address <= tbl_addr[next_idx];
          next_idx++;
        end else begin
          mem_read <= 1'b0;
        end
      end
    end

    repeat (2) @(posedge clk);
    check_count("pmem reads", pmem_reads, expected_reads);
    check_count("pmem_read", int'(s_pread), 0);
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : icache_tb

`default_nettype wire

//--- verification/pmem_model.sv
`default_nettype none

module pmem_model
  import rv32i_types::*;
  import icache_types::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      pmem_read,
  input  rv32i_word pmem_address,
  output logic      pmem_resp,
  output cache_line pmem_rdata,
  output int        read_count
);

  integer    seed = 32'h26c517c5;
  logic      busy = 1'b0;
  logic      resp_q = 1'b0;
  cache_line rdata_q = '0;
  int        wait_cnt = 0;
  int        reads = 0;

  // word k of the line at base holds base + 4k, marked by the xor.
  function automatic cache_line line_at(rv32i_word base);
    cache_line data;
    int        k;
    for (k = 0; k < line_bits / 32; k++) begin
      data[k*32 +: 32] = (base + k * 4) ^ 32'h5a5a_0000;
    end
    return data;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      resp_q <= 1'b0;
      reads  <= 0;
    end else begin
      resp_q <= 1'b0;
      if (busy) begin
        if (wait_cnt <= 1) begin
          resp_q  <= 1'b1;
          rdata_q <= line_at(pmem_address);
          reads   <= reads + 1;
          busy    <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end else if (pmem_read && !resp_q) begin  // read drops after the response.
        busy     <= 1'b1;
        wait_cnt <= 1 + ($unsigned($random(seed)) % 8);
      end
    end
  end

  assign pmem_resp  = resp_q;
  assign pmem_rdata = rdata_q;
  assign read_count = reads;

endmodule : pmem_model

`default_nettype wire

//--- verilog/icache.sv
`default_nettype none

module icache
  import rv32i_types::*;
  import icache_types::*;
#(
  parameter int s_index = 3
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      mem_read,
  input  rv32i_word mem_address,
  input  logic      pmem_resp,
  input  cache_line pmem_rdata,
  output logic      mem_resp,
  output rv32i_word mem_rdata,
  output logic      pmem_read,
  output rv32i_word pmem_address
);

  addrmux_sel_t addr_sel;
  logic         stall;
  logic         fill_load;
  logic         plru_load;
  way_hit_t     fill_way;
  way_hit_t     update_way;
  way_hit_t     victim_way;
  way_hit_t     way_hit;
  logic         hit;
  plru_t        plru;
  cache_line    line;
  rv32i_word    lookup_address;
  stage_reg_t   stage_d;
  stage_reg_t   stage_q;

  icache_control control (
    .clk, .rst,
    .stage_valid (stage_q.valid),
    .stage_hit   (stage_q.hit),
    .stage_way   (stage_q.way_hit),
    .victim_way, .pmem_resp,
    .mem_resp, .stall, .addr_sel, .pmem_read,
    .fill_load, .fill_way, .plru_load, .update_way
  );

  // --------------------
  // stage 1 lookup.
  // --------------------
  always_comb begin
    unique case (addr_sel)
      curr_cpu_address: lookup_address = mem_address;
      prev_cpu_address: lookup_address = stage_q.cpu_address;
    endcase
  end

  icache_metadata_check #(.s_index(s_index)) check (
    .clk, .rst, .lookup_address, .pmem_rdata,
    .fill_load, .plru_load, .fill_way, .update_way,
    .way_hit, .hit, .plru, .line, .victim_way, .pmem_address
  );

  always_comb begin
    stage_d.cpu_address = lookup_address;
    stage_d.valid       = mem_read || (addr_sel == prev_cpu_address);  // replay is a request.
    stage_d.hit         = hit;
    stage_d.way_hit     = way_hit;
    stage_d.plru        = plru;
    stage_d.line        = line;
  end

  always_ff @(posedge clk) begin
    if (rst) stage_q.valid <= 1'b0;
    else if (!stall) stage_q <= stage_d;
  end

  // --------------------
  // stage 2 word select.
  // --------------------
  assign mem_rdata = stage_q.line[{stage_q.cpu_address[4:2], 5'b00000} +: 32];

endmodule : icache

`default_nettype wire

//--- verilog/icache_control.sv
`default_nettype none

module icache_control
  import icache_types::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         stage_valid,
  input  logic         stage_hit,
  input  way_hit_t     stage_way,
  input  way_hit_t     victim_way,
  input  logic         pmem_resp,
  output logic         mem_resp,
  output logic         stall,
  output addrmux_sel_t addr_sel,
  output logic         pmem_read,
  output logic         fill_load,
  output way_hit_t     fill_way,
  output logic         plru_load,
  output way_hit_t     update_way
);

  typedef enum logic [1:0] {
    st_lookup,
    st_fetch,
    st_replay
  } state_t;

  state_t state;
  state_t state_next;
  logic   miss;

  assign miss = stage_valid && !stage_hit;

  always_ff @(posedge clk) begin
    if (rst) state <= st_lookup;
    else     state <= state_next;
  end

  // victim is fixed for the whole refill.
  always_ff @(posedge clk) begin
    if (state == st_lookup && miss) fill_way <= victim_way;
  end

  // --------------------
  // outputs.
  // --------------------
  always_comb begin
    state_next = state;
    mem_resp   = 1'b0;
    stall      = 1'b0;
    addr_sel   = curr_cpu_address;
    pmem_read  = 1'b0;
    fill_load  = 1'b0;
    plru_load  = 1'b0;
    update_way = stage_way;
    unique case (state)
      st_lookup: begin
        mem_resp  = stage_valid && stage_hit;
        plru_load = stage_valid && stage_hit;
        if (miss) begin
          stall      = 1'b1;
          addr_sel   = prev_cpu_address;
          state_next = st_fetch;
        end
      end
      st_fetch: begin
        stall      = 1'b1;
        addr_sel   = prev_cpu_address;
        pmem_read  = 1'b1;
        update_way = fill_way;  // fill counts as an access.
        if (pmem_resp) begin
          fill_load  = 1'b1;
          plru_load  = 1'b1;
          state_next = st_replay;
        end
      end
      st_replay: begin
        addr_sel   = prev_cpu_address;  // relookup of the missed address.
        state_next = st_lookup;
      end
      default: state_next = st_lookup;
    endcase
  end

endmodule : icache_control

`default_nettype wire

//--- verilog/icache_metadata_check.sv
`default_nettype none

module icache_metadata_check
  import rv32i_types::*;
  import icache_types::*;
#(
  parameter int s_index = 3
) (
  input  logic      clk,
  input  logic      rst,
  input  rv32i_word lookup_address,
  input  cache_line pmem_rdata,
  input  logic      fill_load,
  input  logic      plru_load,
  input  way_hit_t  fill_way,
  input  way_hit_t  update_way,
  output way_hit_t  way_hit,
  output logic      hit,
  output plru_t     plru,
  output cache_line line,
  output way_hit_t  victim_way,
  output rv32i_word pmem_address
);

  localparam int s_tag    = 32 - s_offset - s_index;
  localparam int num_sets = 2**s_index;

  logic [s_tag-1:0] tag_q  [num_ways][num_sets];
  cache_line        data_q [num_ways][num_sets];
  way_hit_t         valid_q [num_sets];
  plru_t            plru_q  [num_sets];

  logic [s_index-1:0] rd_set;
  logic [s_tag-1:0]   rd_tag;
  rv32i_word          wr_address;  // the lookup that now sits in stage 2.
  logic [s_index-1:0] wr_set;
  logic [s_tag-1:0]   wr_tag;
  way_hit_t           wr_valid;
  plru_t              wr_plru;

  // points the tree bits away from the accessed way.
  function automatic plru_t plru_touch(plru_t bits, way_hit_t way);
    plru_t next;
    next = bits;
    case (way)
      4'b0001: next = {bits[2], 1'b1, 1'b1};
      4'b0010: next = {bits[2], 1'b0, 1'b1};
      4'b0100: next = {1'b1, bits[1], 1'b0};
      4'b1000: next = {1'b0, bits[1], 1'b0};
      default: next = bits;
    endcase
    return next;
  endfunction

  // lowest invalid way first, then follow the tree.
  function automatic way_hit_t pick_victim(way_hit_t valid, plru_t bits);
    way_hit_t   pick;
    logic [1:0] idx;
    pick = '0;
    idx  = bits[0] ? {1'b1, bits[2]} : {1'b0, bits[1]};
    if (&valid) begin
      pick[idx] = 1'b1;
    end else begin
      for (int w = num_ways - 1; w >= 0; w--) begin
        if (!valid[w]) begin
          pick    = '0;
          pick[w] = 1'b1;
        end
      end
    end
    return pick;
  endfunction

  // --------------------
  // stage 1 read.
  // --------------------
  assign rd_set = lookup_address[s_offset +: s_index];
  assign rd_tag = lookup_address[31 -: s_tag];

  always_comb begin
    line = '0;
    for (int w = 0; w < num_ways; w++) begin
      way_hit[w] = valid_q[rd_set][w] && (tag_q[w][rd_set] == rd_tag);
      if (way_hit[w]) begin
        line = line | data_q[w][rd_set];
      end
    end
  end

  assign hit  = |way_hit;
  assign plru = plru_q[rd_set];

  // --------------------
  // stage 2 side.
  // --------------------
  always_ff @(posedge clk) begin
    wr_address <= lookup_address;  // matches the stage register, also under stall.
  end

  assign wr_set       = wr_address[s_offset +: s_index];
  assign wr_tag       = wr_address[31 -: s_tag];
  assign wr_valid     = valid_q[wr_set];
  assign wr_plru      = plru_q[wr_set];
  assign victim_way   = pick_victim(wr_valid, wr_plru);
  assign pmem_address = {wr_address[31:s_offset], {s_offset{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_q[s] <= '0;
        plru_q[s]  <= '0;
      end
    end else begin
      if (fill_load) valid_q[wr_set] <= wr_valid | fill_way;
      if (plru_load) plru_q[wr_set] <= plru_touch(wr_plru, update_way);
    end
  end

  always_ff @(posedge clk) begin
    if (fill_load) begin
      for (int w = 0; w < num_ways; w++) begin
        if (fill_way[w]) begin
          tag_q[w][wr_set]  <= wr_tag;
          data_q[w][wr_set] <= pmem_rdata;
        end
      end
    end
  end

endmodule : icache_metadata_check

`default_nettype wire

//--- verilog/icache_types.sv
`default_nettype none

package icache_types;
  import rv32i_types::*;

  // --------------------
  // geometry.
  // --------------------
  localparam int s_offset  = 5;   // 32 bytes per line.
  localparam int line_bits = 256;
  localparam int num_ways  = 4;

  typedef logic [line_bits-1:0] cache_line;

  // tree bits: [0] picks the half, [1] ways 0/1, [2] ways 2/3.
  typedef logic [2:0] plru_t;

  typedef logic [num_ways-1:0] way_hit_t;  // one-hot.

  typedef enum logic {
    curr_cpu_address,
    prev_cpu_address
  } addrmux_sel_t;

  // --------------------
  // stage 1 to stage 2.
  // --------------------
  typedef struct packed {
    rv32i_word cpu_address;
    logic      valid;
    logic      hit;
    way_hit_t  way_hit;
    plru_t     plru;
    cache_line line;
  } stage_reg_t;

endpackage : icache_types

`default_nettype wire

//--- verilog/rv32i_types.sv
`default_nettype none

// --------------------
// cpu-facing types.
// --------------------

package rv32i_types;

  // one instruction word or byte address.
  typedef logic [31:0] rv32i_word;

endpackage : rv32i_types

`default_nettype wire
